/* simd_pkg.sv */
// shared sizes, instruction, op and result formats of the SIMD warp core
// 4 lanes of 16 bits, 64-word register SRAM shared by at most 8 warps
`default_nettype none

package simd_pkg;

	// ==============================
	// sizes
	// ==============================
	localparam int VDIM = 4;
	localparam int DBW = 16;
	// register number inside one warp
	localparam int REG_ABW = 3;
	// reg_per_warp may reach 2**REG_ABW, so one extra bit
	localparam int RPW_BW = REG_ABW + 1;
	localparam int SRAM_NWORD = 64;
	localparam int SRAM_ABW = $clog2(SRAM_NWORD);
	localparam int MAX_WARP = 8;
	localparam int WID_BW = $clog2(MAX_WARP);
	localparam int CONST_LUT = 4;

	// one SRAM word or one result with lane 0 in the low bits
	typedef logic [VDIM-1:0][DBW-1:0] lane_vec_t;
	typedef logic [CONST_LUT-1:0][DBW-1:0] const_lut_t;

	// ==============================
	// encodings
	// ==============================
	typedef enum logic [2:0] {
		OP_MAD = 3'd0,
		OP_ADD = 3'd1,
		OP_SUB = 3'd2,
		OP_MAX = 3'd3,
		OP_MIN = 3'd4,
		OP_AND = 3'd5,
		OP_OR  = 3'd6,
		OP_XOR = 3'd7
	} simd_op_e;

	// where an ALU operand comes from
	typedef enum logic [1:0] {
		SRC_CONST = 2'd0,
		SRC_REG   = 2'd1,
		SRC_TEMP  = 2'd2
	} src_sel_e;

	// source fields are 0xxxx direct, 100xx lut, 101xx temp, 11rrr register
	typedef struct packed {
		simd_op_e           opcode;
		logic [4:0]         shamt;
		logic               to_reg;
		logic               to_temp;
		logic [REG_ABW-1:0] dst;
		logic [4:0]         src_a;
		logic [4:0]         src_b;
		logic [4:0]         src_c;
	} simd_inst_t;

	// decoded op, operand stage to ALU
	typedef struct packed {
		simd_op_e            opcode;
		logic [4:0]          shamt;
		src_sel_e            sel_a;
		src_sel_e            sel_b;
		src_sel_e            sel_c;
		logic [DBW-1:0]      const_a;
		logic [DBW-1:0]      const_b;
		logic [DBW-1:0]      const_c;
		logic                to_reg;
		logic                to_temp;
		logic [SRAM_ABW-1:0] waddr;
	} simd_op_t;

	typedef struct packed {
		lane_vec_t           lanes;
		logic [SRAM_ABW-1:0] waddr;
		logic                to_reg;
	} simd_result_t;

endpackage

`default_nettype wire

/* rdyack_forward.sv */
// valid flag of a one-slot stage on a rdy/ack stream
// data registers live in the user module, enabled by o_src_ack
`timescale 1ns/1ps
`default_nettype none

module rdyack_forward (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_src_rdy,
	output logic o_src_ack,
	output logic o_dst_rdy,
	input  logic i_dst_ack
);

	// take new data when empty or drained this cycle
	assign o_src_ack = i_src_rdy && (!o_dst_rdy || i_dst_ack);

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_dst_rdy <= 1'b0;
		end else begin
			// full after a load, empty after a drain with no refill
			o_dst_rdy <= o_src_ack || (o_dst_rdy && !i_dst_ack);
		end
	end

	// the sink only acks a slot that holds data
	a_ack_needs_rdy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_dst_ack |-> o_dst_rdy);

endmodule

`default_nettype wire

/* simd_operand.sv */
// decodes the three source fields, issues the one register read per instruction
// at most one source may name a register; rdata is expected one cycle after ack
`timescale 1ns/1ps
`default_nettype none

module simd_operand import simd_pkg::*; (
	input  logic                i_clk,
	input  logic                i_rst_n,
	// instruction stream
	input  logic                i_inst_rdy,
	output logic                o_inst_ack,
	input  simd_inst_t          i_inst,
	input  logic [WID_BW-1:0]   i_wid,
	// static levels
	input  const_lut_t          i_consts,
	input  logic [RPW_BW-1:0]   i_reg_per_warp,
	// decoded op to the ALU
	output logic                o_op_rdy,
	input  logic                i_op_ack,
	output simd_op_t            o_op,
	// register SRAM read, not bundled with op
	output logic                o_reg_re,
	output logic [SRAM_ABW-1:0] o_reg_raddr
);

	// ==============================
	// decode helpers
	// ==============================
	function automatic src_sel_e src_sel(input logic [4:0] src);
		casez (src)
			5'b0????: return SRC_CONST;
			5'b100??: return SRC_CONST;
			5'b101??: return SRC_TEMP;
			default:  return SRC_REG;
		endcase
	endfunction

	// non-constant sources keep the old constant
	function automatic logic [DBW-1:0] src_const(
		input logic [4:0]     src,
		input logic [DBW-1:0] prev,
		input const_lut_t     consts
	);
		casez (src)
			5'b0????: return DBW'(src[3:0]);
			5'b100??: return consts[src[1:0]];
			default:  return prev;
		endcase
	endfunction

	// ==============================
	// internal
	// ==============================
	src_sel_e            sel_a_w;
	src_sel_e            sel_b_w;
	src_sel_e            sel_c_w;
	logic                reg_a;
	logic                reg_b;
	logic                reg_c;
	logic [REG_ABW-1:0]  reg_idx;
	// address of register 0 of this warp
	logic [SRAM_ABW-1:0] reg_base;
	logic [SRAM_ABW-1:0] waddr_w;

	rdyack_forward u_fwd (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_src_rdy (i_inst_rdy),
		.o_src_ack (o_inst_ack),
		.o_dst_rdy (o_op_rdy),
		.i_dst_ack (i_op_ack)
	);

	// ==============================
	// combinational
	// ==============================
	assign sel_a_w = src_sel(i_inst.src_a);
	assign sel_b_w = src_sel(i_inst.src_b);
	assign sel_c_w = src_sel(i_inst.src_c);
	assign reg_a = (sel_a_w == SRC_REG);
	assign reg_b = (sel_b_w == SRC_REG);
	assign reg_c = (sel_c_w == SRC_REG);

	// register field of the one register source
	always_comb begin
		reg_idx = '0;
		if (reg_a) begin
			reg_idx = i_inst.src_a[REG_ABW-1:0];
		end else if (reg_b) begin
			reg_idx = i_inst.src_b[REG_ABW-1:0];
		end else if (reg_c) begin
			reg_idx = i_inst.src_c[REG_ABW-1:0];
		end
	end

	// warps are packed back to back in the SRAM
	assign reg_base = SRAM_ABW'(i_wid) * SRAM_ABW'(i_reg_per_warp);
	assign o_reg_raddr = reg_base + SRAM_ABW'(reg_idx);
	assign waddr_w = reg_base + SRAM_ABW'(i_inst.dst);
	// read fires with the accept, data arrives with op_rdy
	assign o_reg_re = o_inst_ack && (reg_a || reg_b || reg_c);

	// ==============================
	// sequential
	// ==============================
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_op <= '0;
		end else if (o_inst_ack) begin
			o_op.opcode  <= i_inst.opcode;
			o_op.shamt   <= i_inst.shamt;
			o_op.sel_a   <= sel_a_w;
			o_op.sel_b   <= sel_b_w;
			o_op.sel_c   <= sel_c_w;
			o_op.const_a <= src_const(i_inst.src_a, o_op.const_a, i_consts);
			o_op.const_b <= src_const(i_inst.src_b, o_op.const_b, i_consts);
			o_op.const_c <= src_const(i_inst.src_c, o_op.const_c, i_consts);
			o_op.to_reg  <= i_inst.to_reg;
			o_op.to_temp <= i_inst.to_temp;
			o_op.waddr   <= waddr_w;
		end
	end

	// single read port, so one register source per instruction
	a_one_reg_src: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_inst_ack |-> $countones({reg_a, reg_b, reg_c}) <= 1);

endmodule

`default_nettype wire

/* warp_reg_sram.sv */
// register SRAM, one read and one write port, registered read output
// rdata holds until the next read; init writes lose to pipeline writes
`timescale 1ns/1ps
`default_nettype none

module warp_reg_sram import simd_pkg::*; (
	input  logic                i_clk,
	input  logic                i_rst_n,
	// read port
	input  logic                i_re,
	input  logic [SRAM_ABW-1:0] i_raddr,
	output lane_vec_t           o_rdata,
	// pipeline write port
	input  logic                i_we,
	input  logic [SRAM_ABW-1:0] i_waddr,
	input  lane_vec_t           i_wdata,
	// preload port
	input  logic                i_init_we,
	input  logic [SRAM_ABW-1:0] i_init_addr,
	input  lane_vec_t           i_init_data
);

	lane_vec_t mem [SRAM_NWORD];

	always_ff @(posedge i_clk) begin
		if (i_we) begin
			mem[i_waddr] <= i_wdata;
		end else if (i_init_we) begin
			mem[i_init_addr] <= i_init_data;
		end
	end

	// write-to-read bypass keeps back to back instructions in order
	always_ff @(posedge i_clk) begin
		if (i_re) begin
			if (i_we && (i_waddr == i_raddr)) begin
				o_rdata <= i_wdata;
			end else begin
				o_rdata <= mem[i_raddr];
			end
		end
	end

	// preloading is only done while the pipeline is idle
	a_no_init_clash: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(i_we && i_init_we));

endmodule

`default_nettype wire

/* simd_alu.sv */
// lane-wise signed ALU with arithmetic right shift, 16-bit wrap
// rdata must be the word read for the op now offered
`timescale 1ns/1ps
`default_nettype none

module simd_alu import simd_pkg::*; (
	input  logic                i_clk,
	input  logic                i_rst_n,
	// decoded op
	input  logic                i_op_rdy,
	output logic                o_op_ack,
	input  simd_op_t            i_op,
	input  lane_vec_t           i_rdata,
	// write back
	output logic                o_we,
	output logic [SRAM_ABW-1:0] o_waddr,
	output lane_vec_t           o_wdata,
	// result stream
	output logic                o_res_rdy,
	input  logic                i_res_ack,
	output simd_result_t        o_res
);

	// ==============================
	// lane helpers
	// ==============================
	// constants are broadcast to all lanes
	function automatic logic [DBW-1:0] pick_opnd(
		input src_sel_e       sel,
		input logic [DBW-1:0] cst,
		input logic [DBW-1:0] rd,
		input logic [DBW-1:0] tmp
	);
		case (sel)
			SRC_REG:  return rd;
			SRC_TEMP: return tmp;
			default:  return cst;
		endcase
	endfunction

	function automatic logic signed [DBW-1:0] alu_lane(
		input simd_op_e              op,
		input logic signed [DBW-1:0] a,
		input logic signed [DBW-1:0] b,
		input logic signed [DBW-1:0] c
	);
		case (op)
			OP_MAD:  return a * b + c;
			OP_ADD:  return a + b + c;
			OP_SUB:  return a - b + c;
			OP_MAX:  return (a > b) ? a : b;
			OP_MIN:  return (a < b) ? a : b;
			OP_AND:  return a & b & c;
			OP_OR:   return a | b | c;
			default: return a ^ b ^ c;
		endcase
	endfunction

	// ==============================
	// internal
	// ==============================
	lane_vec_t opnd_a;
	lane_vec_t opnd_b;
	lane_vec_t opnd_c;
	lane_vec_t alu_out;
	// single temp slot shared by all warps
	lane_vec_t temp;

	rdyack_forward u_fwd (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_src_rdy (i_op_rdy),
		.o_src_ack (o_op_ack),
		.o_dst_rdy (o_res_rdy),
		.i_dst_ack (i_res_ack)
	);

	always_comb begin
		for (int l = 0; l < VDIM; l++) begin
			opnd_a[l] = pick_opnd(i_op.sel_a, i_op.const_a, i_rdata[l], temp[l]);
			opnd_b[l] = pick_opnd(i_op.sel_b, i_op.const_b, i_rdata[l], temp[l]);
			opnd_c[l] = pick_opnd(i_op.sel_c, i_op.const_c, i_rdata[l], temp[l]);
			// signed return makes the shift fill with the sign bit
			alu_out[l] = alu_lane(i_op.opcode, opnd_a[l], opnd_b[l], opnd_c[l])
				>>> i_op.shamt;
		end
	end

	// write back lands on the op accept edge
	assign o_we = o_op_ack && i_op.to_reg;
	assign o_waddr = i_op.waddr;
	assign o_wdata = alu_out;

	// ==============================
	// sequential
	// ==============================
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			temp <= '0;
		end else if (o_op_ack && i_op.to_temp) begin
			temp <= alu_out;
		end
	end

	always_ff @(posedge i_clk) begin
		if (o_op_ack) begin
			o_res.lanes  <= alu_out;
			o_res.waddr  <= i_op.waddr;
			o_res.to_reg <= i_op.to_reg;
		end
	end

endmodule

`default_nettype wire

/* simd_core_top.sv */
// operand stage, register SRAM and ALU of one SIMD warp pipeline
// two cycles from inst ack to res_rdy without stalls; preload only while idle
`timescale 1ns/1ps
`default_nettype none

module simd_core_top import simd_pkg::*; (
	input  logic                i_clk,
	input  logic                i_rst_n,
	// instruction stream
	input  logic                i_inst_rdy,
	output logic                o_inst_ack,
	input  simd_inst_t          i_inst,
	input  logic [WID_BW-1:0]   i_wid,
	// static levels
	input  const_lut_t          i_consts,
	input  logic [RPW_BW-1:0]   i_reg_per_warp,
	// SRAM preload
	input  logic                i_init_we,
	input  logic [SRAM_ABW-1:0] i_init_addr,
	input  lane_vec_t           i_init_data,
	// result stream
	output logic                o_res_rdy,
	input  logic                i_res_ack,
	output simd_result_t        o_res
);

	// ==============================
	// stage to stage wires
	// ==============================
	logic                op_rdy;
	logic                op_ack;
	simd_op_t            op;
	logic                reg_re;
	logic [SRAM_ABW-1:0] reg_raddr;
	lane_vec_t           rdata;
	logic                we;
	logic [SRAM_ABW-1:0] waddr;
	lane_vec_t           wdata;

	simd_operand u_operand (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_inst_rdy     (i_inst_rdy),
		.o_inst_ack     (o_inst_ack),
		.i_inst         (i_inst),
		.i_wid          (i_wid),
		.i_consts       (i_consts),
		.i_reg_per_warp (i_reg_per_warp),
		.o_op_rdy       (op_rdy),
		.i_op_ack       (op_ack),
		.o_op           (op),
		.o_reg_re       (reg_re),
		.o_reg_raddr    (reg_raddr)
	);

	warp_reg_sram u_sram (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_re        (reg_re),
		.i_raddr     (reg_raddr),
		.o_rdata     (rdata),
		.i_we        (we),
		.i_waddr     (waddr),
		.i_wdata     (wdata),
		.i_init_we   (i_init_we),
		.i_init_addr (i_init_addr),
		.i_init_data (i_init_data)
	);

	simd_alu u_alu (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_op_rdy  (op_rdy),
		.o_op_ack  (op_ack),
		.i_op      (op),
		.i_rdata   (rdata),
		.o_we      (we),
		.o_waddr   (waddr),
		.o_wdata   (wdata),
		.o_res_rdy (o_res_rdy),
		.i_res_ack (i_res_ack),
		.o_res     (o_res)
	);

endmodule

`default_nettype wire

/* tb_simd_core.sv */
// reads simd_core_tests.txt from the working directory, so run it from the project root
// config and preload lines wait for an empty pipeline; results are checked in issue order
`timescale 1ns/1ps
`default_nettype none

module tb_simd_core import simd_pkg::*; ();

	// ==============================
	// limits
	// ==============================
	localparam int RESET_CYCLES = 10;
	// longest single wait in cycles
	localparam int WAIT_LIMIT = 500;
	localparam int MAX_TESTS = 256;

	logic                i_clk;
	logic                i_rst_n;
	logic                i_inst_rdy;
	logic                o_inst_ack;
	simd_inst_t          i_inst;
	logic [WID_BW-1:0]   i_wid;
	const_lut_t          i_consts;
	logic [RPW_BW-1:0]   i_reg_per_warp;
	logic                i_init_we;
	logic [SRAM_ABW-1:0] i_init_addr;
	lane_vec_t           i_init_data;
	logic                o_res_rdy;
	// driven by the stall process only
	logic                i_res_ack = 1'b0;
	simd_result_t        o_res;

	// ==============================
	// scoreboard
	// ==============================
	// expected results in issue order
	simd_result_t exp_mem [MAX_TESTS];
	int           issued = 0;
	int           checked = 0;
	int           pass_cnt = 0;
	int           fail_cnt = 0;
	logic         aborted = 1'b0;
	logic         stall_on = 1'b0;
	integer       seed = 32'hd06b;

	simd_core_top u_dut (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_inst_rdy     (i_inst_rdy),
		.o_inst_ack     (o_inst_ack),
		.i_inst         (i_inst),
		.i_wid          (i_wid),
		.i_consts       (i_consts),
		.i_reg_per_warp (i_reg_per_warp),
		.i_init_we      (i_init_we),
		.i_init_addr    (i_init_addr),
		.i_init_data    (i_init_data),
		.o_res_rdy      (o_res_rdy),
		.i_res_ack      (i_res_ack),
		.o_res          (o_res)
	);

	// 20 ns period
	initial i_clk = 1'b0;
	always #10 i_clk = ~i_clk;

	// random back-pressure that acks only while rdy
	always @(negedge i_clk) begin
		if (stall_on) begin
			i_res_ack = o_res_rdy && (($random(seed) & 3) != 0);
		end else begin
			i_res_ack = 1'b0;
		end
	end

	task automatic check_result(input simd_result_t got, input simd_result_t want, input int idx);
		if (got !== want) begin
			fail_cnt++;
			$write("Fail at %0t ns: test %0d got lanes %h waddr %0d to_reg %0b", $time, idx,
				got.lanes, got.waddr, got.to_reg);
			$display(" expected lanes %h waddr %0d to_reg %0b", want.lanes, want.waddr,
				want.to_reg);
		end else begin
			pass_cnt++;
			$display("test %0d ok: lanes %h waddr %0d to_reg %0b", idx, got.lanes, got.waddr,
				got.to_reg);
		end
	endtask

	// a transfer on the result stream retires the oldest pending test
	always @(posedge i_clk) begin
		if (i_rst_n && o_res_rdy && i_res_ack) begin
			if (checked >= issued) begin
				fail_cnt++;
				$display("unexpected result at %0t ns with no instruction pending", $time);
			end else begin
				check_result(o_res, exp_mem[checked], checked + 1);
				checked++;
			end
		end
	end

	// ==============================
	// stimulus helpers
	// ==============================
	task automatic issue_inst(input simd_inst_t inst, input logic [WID_BW-1:0] wid,
		input simd_result_t want);
		int waited;
		waited = 0;
		i_inst = inst;
		i_wid = wid;
		i_inst_rdy = 1'b1;
		@(posedge i_clk);
		while (!o_inst_ack && waited < WAIT_LIMIT) begin
			waited++;
			@(posedge i_clk);
		end
		if (o_inst_ack) begin
			exp_mem[issued] = want;
			issued++;
		end else begin
			aborted = 1'b1;
			$display("timeout: instruction %0d was never accepted", issued + 1);
		end
		@(negedge i_clk);
		i_inst_rdy = 1'b0;
	endtask

	task automatic drain_pipeline();
		int waited;
		waited = 0;
		while (checked != issued && waited < WAIT_LIMIT) begin
			waited++;
			@(negedge i_clk);
		end
		if (checked != issued) begin
			aborted = 1'b1;
			$display("timeout: %0d results never came out", issued - checked);
		end
	endtask

	// one init write while the pipeline is idle
	task automatic preload_word(input logic [SRAM_ABW-1:0] addr, input lane_vec_t data);
		i_init_we = 1'b1;
		i_init_addr = addr;
		i_init_data = data;
		@(negedge i_clk);
		i_init_we = 1'b0;
	endtask

	task automatic flag_bad_line(input int ln);
		aborted = 1'b1;
		$display("line %0d of the tests file could not be parsed", ln);
	endtask

	// ==============================
	// main sequence
	// ==============================
	initial begin
		int           fd;
		int           n;
		int           ln;
		int           f [16];
		string        line;
		simd_inst_t   inst;
		simd_result_t want;
		lane_vec_t    lanes;
		i_rst_n = 1'b0;
		i_inst_rdy = 1'b0;
		i_inst = '0;
		i_wid = '0;
		i_consts = '0;
		i_reg_per_warp = '0;
		i_init_we = 1'b0;
		i_init_addr = '0;
		i_init_data = '0;
		repeat (RESET_CYCLES) @(negedge i_clk);
		i_rst_n = 1'b1;
		stall_on = 1'b1;
		fd = $fopen("simd_core_tests.txt", "r");
		if (fd == 0) begin
			aborted = 1'b1;
			$display("cannot open simd_core_tests.txt");
		end
		ln = 0;
		while (!aborted && fd != 0 && !$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			ln++;
			if (n > 0) begin
				case (line.getc(0))
					"C": begin
						n = $sscanf(line, "C %d %h %h %h %h", f[0], f[1], f[2], f[3], f[4]);
						if (n != 5) begin
							flag_bad_line(ln);
						end else begin
							// static levels only change with an empty pipeline
							drain_pipeline();
							i_reg_per_warp = f[0][RPW_BW-1:0];
							for (int k = 0; k < CONST_LUT; k++) begin
								i_consts[k] = f[1+k][DBW-1:0];
							end
						end
					end
					"P": begin
						n = $sscanf(line, "P %d %h %h %h %h", f[0], f[1], f[2], f[3], f[4]);
						if (n != 5) begin
							flag_bad_line(ln);
						end else begin
							drain_pipeline();
							for (int k = 0; k < VDIM; k++) begin
								lanes[k] = f[1+k][DBW-1:0];
							end
							preload_word(f[0][SRAM_ABW-1:0], lanes);
						end
					end
					"I": begin
						n = $sscanf(line, "I %d %d %d %d %d %b %b %b %d %h %h %h %h %d %d",
							f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
							f[9], f[10], f[11], f[12], f[13], f[14]);
						if (n != 15 || issued >= MAX_TESTS) begin
							flag_bad_line(ln);
						end else begin
							inst.opcode = simd_op_e'(f[0][2:0]);
							inst.shamt = f[1][4:0];
							inst.to_reg = f[2][0];
							inst.to_temp = f[3][0];
							inst.dst = f[4][REG_ABW-1:0];
							inst.src_a = f[5][4:0];
							inst.src_b = f[6][4:0];
							inst.src_c = f[7][4:0];
							for (int k = 0; k < VDIM; k++) begin
								want.lanes[k] = f[9+k][DBW-1:0];
							end
							want.waddr = f[13][SRAM_ABW-1:0];
							want.to_reg = f[14][0];
							issue_inst(inst, f[8][WID_BW-1:0], want);
						end
					end
					// comments and blank lines
					"#", "\n", "\r", " ": begin
					end
					default: begin
						flag_bad_line(ln);
					end
				endcase
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end
		if (!aborted) begin
			drain_pipeline();
		end
		$display("%0d issued, %0d passed, %0d failed", issued, pass_cnt, fail_cnt);
		if (!aborted && fail_cnt == 0 && issued > 0 && pass_cnt == issued) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* simd_core_tests.txt */
# C rpw k0 k1 k2 k3 / P addr lane0 lane1 lane2 lane3 (rpw and addr decimal, lanes hex)
# I op shamt to_reg to_temp dst src_a src_b src_c wid exp_lane0..3 exp_waddr exp_to_reg
# op 0 mad 1 add 2 sub 3 max 4 min 5 and 6 or 7 xor, sources binary, wid and waddr decimal
C 8 0100 fff0 0007 8000
# direct and lookup constants, every opcode
I 0 0 0 0 1 00011 00101 10010 0 0016 0016 0016 0016 1 0
I 1 4 0 0 2 10000 01111 00001 0 0011 0011 0011 0011 2 0
I 2 1 0 0 3 00010 10000 00000 0 ff81 ff81 ff81 ff81 3 0
I 3 0 0 0 4 10001 01001 00000 0 0009 0009 0009 0009 4 0
I 4 2 0 0 5 10001 01001 00000 0 fffc fffc fffc fffc 5 0
I 5 3 0 0 6 10001 10011 10001 0 f000 f000 f000 f000 6 0
I 6 0 0 0 7 00001 00110 10000 0 0107 0107 0107 0107 7 0
I 7 0 0 0 0 10001 01111 10010 0 fff8 fff8 fff8 fff8 0 0
I 0 0 0 0 1 10011 00010 00101 0 0005 0005 0005 0005 1 0
# register preloads
P 0 0001 0002 0003 0004
P 3 0010 ffff 7fff 8000
P 9 0005 fffb 0100 0000
P 23 1234 00ff f00f 0001
# register sources in several warps
I 1 0 0 0 4 11000 00001 00000 0 0002 0003 0004 0005 4 0
I 0 0 0 0 6 11001 00011 10010 1 0016 fff8 0307 0007 14 0
I 2 0 0 0 0 00000 11111 00000 2 edcc ff01 0ff1 ffff 16 0
I 3 0 0 0 5 11011 00000 00000 0 0010 0000 7fff 0000 5 0
I 4 4 0 0 7 11011 10001 00000 0 ffff ffff ffff f800 7 0
# write back read by the very next instruction
I 1 0 1 0 2 11000 01010 00000 0 000b 000c 000d 000e 2 1
I 7 0 1 0 2 11010 10000 00000 0 010b 010c 010d 010e 2 1
I 2 0 0 0 3 11010 01011 00000 0 0100 0101 0102 0103 3 0
I 1 0 1 0 3 11001 00000 00000 1 0005 fffb 0100 0000 11 1
I 0 0 0 0 0 11011 00010 00001 1 000b fff7 0201 0001 8 0
# temp register, then the same values without it
I 1 0 0 1 0 00111 01000 00000 0 000f 000f 000f 000f 0 0
I 0 0 0 0 1 10100 00010 00001 0 001f 001f 001f 001f 1 0
I 0 0 0 0 1 01111 00010 00001 0 001f 001f 001f 001f 1 0
I 1 0 0 1 1 11000 10100 00000 0 0010 0011 0012 0013 1 0
I 2 0 0 0 6 10101 11000 00000 0 000f 000f 000f 000f 6 0
I 2 0 0 0 6 01111 00000 00000 0 000f 000f 000f 000f 6 0
# other warp size and constants
C 5 0003 ffff 0040 0002
I 1 0 0 0 4 11011 00001 00000 4 1235 0100 f010 0002 24 0
I 6 1 0 0 2 10010 10011 00001 7 0021 0021 0021 0021 37 0
I 0 1 0 0 0 10001 10000 00000 0 fffe fffe fffe fffe 0 0

/* files.f */
simd_pkg.sv
rdyack_forward.sv
simd_operand.sv
warp_reg_sram.sv
simd_alu.sv
simd_core_top.sv
tb_simd_core.sv

/* Makefile */
# Verilator build and run of the SIMD core testbench

VERILATOR ?= verilator
TOP       ?= tb_simd_core
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= ALL CHECKS PASSED

BIN  := $(BUILD_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the exit status comes from the search for the pass line
run: $(BIN)
	@out="$$($(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
